/* rtl/soc_map_pkg.sv */
// Register map of the hart timer block; regions are half-open, address bits [2:0] are ignored
package soc_map_pkg;

  localparam int unsigned AddrWidth  = 32;
  localparam int unsigned NumRegions = 3;

  // ------------------------------------------------------------
  // Region bases and per-hart strides
  // ------------------------------------------------------------
  localparam logic [AddrWidth-1:0] MsipBase       = 32'h0000_0000;
  localparam int unsigned          MsipStride     = 8;
  localparam logic [AddrWidth-1:0] MtimecmpBase   = 32'h0000_4000;
  localparam int unsigned          MtimecmpStride = 8;
  localparam logic [AddrWidth-1:0] MtimeBase      = 32'h0000_BFF8;

  typedef enum logic [1:0] {
    MSIP     = 2'd0,
    MTIMECMP = 2'd1,
    MTIME    = 2'd2
  } region_e;

  // End address is exclusive
  typedef struct packed {
    logic [AddrWidth-1:0] start_addr;
    logic [AddrWidth-1:0] end_addr;
    region_e              idx;
  } addr_rule_t;

  // msip and mtimecmp keep the full CLINT window, unused hart slots miss
  localparam addr_rule_t AddrMap [NumRegions] = '{
    '{
      start_addr: MsipBase,
      end_addr:   MtimecmpBase,
      idx:        MSIP
    },
    '{
      start_addr: MtimecmpBase,
      end_addr:   MtimeBase,
      idx:        MTIMECMP
    },
    '{
      start_addr: MtimeBase,
      end_addr:   MtimeBase + 32'd8,
      idx:        MTIME
    }
  };

endpackage

/* rtl/hart_ctrl_pkg.sv */
// Hart count and widths; TimeWidth must not exceed DataWidth, NumHarts at least 1
package hart_ctrl_pkg;

  localparam int unsigned NumHarts = 4;

  localparam int unsigned HartIdxWidth = (NumHarts > 1) ? $clog2(NumHarts) : 1;

  // ------------------------------------------------------------
  // Data path
  // ------------------------------------------------------------
  localparam int unsigned DataWidth = 64;
  localparam int unsigned TimeWidth = 64;

  // No timer interrupt until software programs a compare value
  localparam logic [TimeWidth-1:0] MtimecmpReset = {TimeWidth{1'b1}};

  // ------------------------------------------------------------
  // Debug request hold-off
  // ------------------------------------------------------------
  // Gives the harts time to run init code before the first halt
  localparam int unsigned DebugDelayCycles = 64;
  localparam int unsigned DebugCntWidth    = $clog2(DebugDelayCycles + 1);

endpackage

/* rtl/mtime_counter.sv */
// rtc_i must be slower than clk_i/4 so that every level is seen by the two-flop synchronizer
`timescale 1ns/1ps

module mtime_counter
  import hart_ctrl_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 ndmreset_n,
  input  logic                 rtc_i,
  input  logic                 mtime_we_i,
  input  logic [DataWidth-1:0] wdata_i,
  output logic [TimeWidth-1:0] mtime_o
);

  // [1:0] synchronizer, [2] previous sample for edge detect
  logic [2:0]           rtc_sync_q;
  logic                 rtc_rise;
  logic                 rtc_div_q;
  logic                 mtime_tick;
  logic [TimeWidth-1:0] mtime_q;

  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_rtc_sync
    if (!ndmreset_n) begin
      rtc_sync_q <= '0;
    end else begin
      rtc_sync_q <= {rtc_sync_q[1:0], rtc_i};
    end
  end

  assign rtc_rise = rtc_sync_q[1] & ~rtc_sync_q[2];

  // Divide by two, tick on every second edge
  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_rtc_div
    if (!ndmreset_n) begin
      rtc_div_q <= 1'b0;
    end else if (rtc_rise) begin
      rtc_div_q <= ~rtc_div_q;
    end
  end

  assign mtime_tick = rtc_rise & rtc_div_q;

  // Bus write has priority over the tick
  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_mtime
    if (!ndmreset_n) begin
      mtime_q <= '0;
    end else if (mtime_we_i) begin
      mtime_q <= wdata_i[TimeWidth-1:0];
    end else if (mtime_tick) begin
      mtime_q <= mtime_q + 1'b1;
    end
  end

  assign mtime_o = mtime_q;

  a_mtime_monotonic: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    !$past(mtime_we_i) |-> (mtime_o >= $past(mtime_o))
  );

endmodule

/* rtl/clint_addr_decoder.sv */
// Purely combinational; hart slots past NumHarts inside a region are reported as a miss
`timescale 1ns/1ps

module clint_addr_decoder
  import soc_map_pkg::*;
  import hart_ctrl_pkg::*;
(
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] addr_i,
  output logic [NumHarts-1:0]  msip_sel_o,
  output logic [NumHarts-1:0]  cmp_sel_o,
  output logic                 mtime_sel_o,
  output logic                 write_o,
  output logic                 read_o,
  output logic                 miss_o
);

  logic [AddrWidth-1:0]    word_addr;
  logic                    hit;
  region_e                 region;
  logic [AddrWidth-1:0]    rel_addr;
  logic [AddrWidth-1:0]    slot;
  logic [HartIdxWidth-1:0] hart_idx;
  logic                    mapped;

  // Whole 64-bit words only
  assign word_addr = {addr_i[AddrWidth-1:3], 3'b000};

  always_comb begin : p_match
    hit      = 1'b0;
    region   = MSIP;
    rel_addr = '0;
    for (int unsigned i = 0; i < NumRegions; i++) begin
      if (!hit && word_addr >= AddrMap[i].start_addr && word_addr < AddrMap[i].end_addr) begin
        hit      = 1'b1;
        region   = AddrMap[i].idx;
        rel_addr = word_addr - AddrMap[i].start_addr;
      end
    end
  end

  always_comb begin : p_slot
    case (region)
      MSIP:     slot = rel_addr / MsipStride;
      MTIMECMP: slot = rel_addr / MtimecmpStride;
      default:  slot = '0;
    endcase
  end

  assign hart_idx = slot[HartIdxWidth-1:0];
  assign mapped   = hit && (slot < NumHarts);

  always_comb begin : p_select
    msip_sel_o  = '0;
    cmp_sel_o   = '0;
    mtime_sel_o = 1'b0;
    if (req_i && mapped) begin
      case (region)
        MSIP:     msip_sel_o[hart_idx] = 1'b1;
        MTIMECMP: cmp_sel_o[hart_idx]  = 1'b1;
        default:  mtime_sel_o          = 1'b1;
      endcase
    end
  end

  assign write_o = req_i & we_i & mapped;
  assign read_o  = req_i & ~we_i & mapped;
  assign miss_o  = req_i & ~mapped;

  a_sel_onehot: assert final ($onehot0({msip_sel_o, cmp_sel_o, mtime_sel_o, miss_o}));

endmodule

/* rtl/hart_timer_slice.sv */
// One hart; full-word writes only, msip is bit 0 of the word and reads back zero-extended
`timescale 1ns/1ps

module hart_timer_slice
  import hart_ctrl_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 ndmreset_n,
  input  logic                 msip_sel_i,
  input  logic                 cmp_sel_i,
  input  logic                 write_i,
  input  logic [DataWidth-1:0] wdata_i,
  input  logic [TimeWidth-1:0] mtime_i,
  output logic [DataWidth-1:0] rdata_o,
  output logic                 timer_irq_o,
  output logic                 ipi_o
);

  logic                 msip_q;
  logic [TimeWidth-1:0] cmp_q;
  logic                 cmp_hit;
  logic                 timer_irq_q;
  logic                 ipi_q;

  // ------------------------------------------------------------
  // Registers
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_regs
    if (!ndmreset_n) begin
      msip_q <= 1'b0;
      cmp_q  <= MtimecmpReset;
    end else if (write_i) begin
      if (msip_sel_i) begin
        msip_q <= wdata_i[0];
      end
      if (cmp_sel_i) begin
        cmp_q <= wdata_i[TimeWidth-1:0];
      end
    end
  end

  // ------------------------------------------------------------
  // Interrupts
  // ------------------------------------------------------------
  assign cmp_hit = (mtime_i >= cmp_q);

  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_irq
    if (!ndmreset_n) begin
      timer_irq_q <= 1'b0;
      ipi_q       <= 1'b0;
    end else begin
      timer_irq_q <= cmp_hit;
      ipi_q       <= msip_q;
    end
  end

  assign timer_irq_o = timer_irq_q;
  assign ipi_o       = ipi_q;

  // Zero unless selected, so the collector can OR all slices
  always_comb begin : p_rdata
    rdata_o = '0;
    if (msip_sel_i) begin
      rdata_o = {{(DataWidth-1){1'b0}}, msip_q};
    end else if (cmp_sel_i) begin
      rdata_o = DataWidth'(cmp_q);
    end
  end

  a_no_stale_irq: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    (mtime_i < cmp_q) |=> !timer_irq_o
  );

endmodule

/* rtl/hart_irq_collector.sv */
// Response comes one cycle after the request; rdata_o is only meaningful while rvalid_o is high
`timescale 1ns/1ps

module hart_irq_collector
  import hart_ctrl_pkg::*;
(
  input  logic                                clk_i,
  input  logic                                ndmreset_n,
  input  logic                                read_i,
  input  logic                                miss_i,
  input  logic                                mtime_sel_i,
  input  logic [NumHarts-1:0][DataWidth-1:0]  slice_rdata_i,
  input  logic [TimeWidth-1:0]                mtime_i,
  input  logic [NumHarts-1:0]                 debug_req_i,
  output logic [DataWidth-1:0]                rdata_o,
  output logic                                rvalid_o,
  output logic                                decode_err_o,
  output logic [NumHarts-1:0]                 debug_req_o
);

  logic                     resp_d;
  logic [DataWidth-1:0]     rdata_d;
  logic [DataWidth-1:0]     rdata_q;
  logic                     rvalid_q;
  logic                     decode_err_q;
  logic [DebugCntWidth-1:0] dly_cnt_q;

  // ------------------------------------------------------------
  // Read response
  // ------------------------------------------------------------
  // A miss answers on writes too, with zero data
  assign resp_d = read_i | miss_i;

  always_comb begin : p_rdata_or
    rdata_d = '0;
    for (int unsigned h = 0; h < NumHarts; h++) begin
      rdata_d = rdata_d | slice_rdata_i[h];
    end
    if (mtime_sel_i) begin
      rdata_d = rdata_d | DataWidth'(mtime_i);
    end
  end

  always_ff @(posedge clk_i) begin : p_rdata
    if (resp_d) begin
      rdata_q <= rdata_d;
    end
  end

  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_resp
    if (!ndmreset_n) begin
      rvalid_q     <= 1'b0;
      decode_err_q <= 1'b0;
    end else begin
      rvalid_q     <= resp_d;
      decode_err_q <= miss_i;
    end
  end

  assign rdata_o      = rdata_q;
  assign rvalid_o     = rvalid_q;
  assign decode_err_o = decode_err_q;

  // ------------------------------------------------------------
  // Debug request gate
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge ndmreset_n) begin : p_dly_cnt
    if (!ndmreset_n) begin
      dly_cnt_q <= DebugCntWidth'(DebugDelayCycles);
    end else if (dly_cnt_q != '0) begin
      dly_cnt_q <= dly_cnt_q - 1'b1;
    end
  end

  assign debug_req_o = (dly_cnt_q != '0) ? '0 : debug_req_i;

  a_rvalid_b2b: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    (rvalid_o && $past(rvalid_o)) |-> ($past(resp_d) && $past(resp_d, 2))
  );

  a_err_b2b: assert property (
    @(posedge clk_i) disable iff (!ndmreset_n)
    (decode_err_o && $past(decode_err_o)) |-> ($past(miss_i) && $past(miss_i, 2))
  );

endmodule

/* rtl/clint_subsystem.sv */
// Plain strobe bus without back-pressure; every request is taken in the cycle req_i is high
`timescale 1ns/1ps

module clint_subsystem
  import soc_map_pkg::*;
  import hart_ctrl_pkg::*;
(
  input  logic                 clk_i,
  input  logic                 ndmreset_n,
  input  logic                 req_i,
  input  logic                 we_i,
  input  logic [AddrWidth-1:0] addr_i,
  input  logic [DataWidth-1:0] wdata_i,
  input  logic                 rtc_i,
  input  logic [NumHarts-1:0]  debug_req_i,
  output logic [DataWidth-1:0] rdata_o,
  output logic                 rvalid_o,
  output logic                 decode_err_o,
  output logic [NumHarts-1:0]  timer_irq_o,
  output logic [NumHarts-1:0]  ipi_o,
  output logic [NumHarts-1:0]  debug_req_o
);

  logic [NumHarts-1:0]                msip_sel;
  logic [NumHarts-1:0]                cmp_sel;
  logic                               mtime_sel;
  logic                               write;
  logic                               read;
  logic                               miss;
  logic [TimeWidth-1:0]               mtime;
  logic [NumHarts-1:0][DataWidth-1:0] slice_rdata;

  // ------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------
  clint_addr_decoder i_decoder (
    .req_i       ( req_i     ),
    .we_i        ( we_i      ),
    .addr_i      ( addr_i    ),
    .msip_sel_o  ( msip_sel  ),
    .cmp_sel_o   ( cmp_sel   ),
    .mtime_sel_o ( mtime_sel ),
    .write_o     ( write     ),
    .read_o      ( read      ),
    .miss_o      ( miss      )
  );

  // ------------------------------------------------------------
  // Real-time counter
  // ------------------------------------------------------------
  mtime_counter i_mtime (
    .clk_i      ( clk_i             ),
    .ndmreset_n ( ndmreset_n        ),
    .rtc_i      ( rtc_i             ),
    .mtime_we_i ( write & mtime_sel ),
    .wdata_i    ( wdata_i           ),
    .mtime_o    ( mtime             )
  );

  // ------------------------------------------------------------
  // Per-hart registers
  // ------------------------------------------------------------
  for (genvar h = 0; h < NumHarts; h++) begin : g_hart
    hart_timer_slice i_slice (
      .clk_i       ( clk_i          ),
      .ndmreset_n  ( ndmreset_n     ),
      .msip_sel_i  ( msip_sel[h]    ),
      .cmp_sel_i   ( cmp_sel[h]     ),
      .write_i     ( write          ),
      .wdata_i     ( wdata_i        ),
      .mtime_i     ( mtime          ),
      .rdata_o     ( slice_rdata[h] ),
      .timer_irq_o ( timer_irq_o[h] ),
      .ipi_o       ( ipi_o[h]       )
    );
  end

  // Response path and debug gate
  hart_irq_collector i_collector (
    .clk_i         ( clk_i        ),
    .ndmreset_n    ( ndmreset_n   ),
    .read_i        ( read         ),
    .miss_i        ( miss         ),
    .mtime_sel_i   ( mtime_sel    ),
    .slice_rdata_i ( slice_rdata  ),
    .mtime_i       ( mtime        ),
    .debug_req_i   ( debug_req_i  ),
    .rdata_o       ( rdata_o      ),
    .rvalid_o      ( rvalid_o     ),
    .decode_err_o  ( decode_err_o ),
    .debug_req_o   ( debug_req_o  )
  );

endmodule

/* testbench/tb_clint_subsystem.sv */
// Self-checking testbench; rtc_i only toggles in the mtime test, so mtime is still elsewhere
`timescale 1ns/1ps

module tb_clint_subsystem
  import soc_map_pkg::*;
  import hart_ctrl_pkg::*;
();

  localparam int unsigned Timeout = 20;

  typedef struct packed {
    logic                 we;
    logic [AddrWidth-1:0] addr;
    logic [DataWidth-1:0] wdata;
    logic [DataWidth-1:0] exp_rdata;
    logic                 exp_err;
  } step_t;

  logic                 clk_i;
  logic                 ndmreset_n;
  logic                 req_i;
  logic                 we_i;
  logic [AddrWidth-1:0] addr_i;
  logic [DataWidth-1:0] wdata_i;
  logic                 rtc_i;
  logic [NumHarts-1:0]  debug_req_i;
  logic [DataWidth-1:0] rdata_o;
  logic                 rvalid_o;
  logic                 decode_err_o;
  logic [NumHarts-1:0]  timer_irq_o;
  logic [NumHarts-1:0]  ipi_o;
  logic [NumHarts-1:0]  debug_req_o;

  step_t                table_q [$];
  logic [TimeWidth-1:0] mtime_model;
  logic [TimeWidth-1:0] cmp_model [NumHarts];
  logic                 msip_model [NumHarts];
  logic [DataWidth-1:0] rand_word [NumHarts];
  int                   value_errs;
  int                   timeout_errs;

  clint_subsystem u_clint_subsystem (
    .clk_i        ( clk_i        ),
    .ndmreset_n   ( ndmreset_n   ),
    .req_i        ( req_i        ),
    .we_i         ( we_i         ),
    .addr_i       ( addr_i       ),
    .wdata_i      ( wdata_i      ),
    .rtc_i        ( rtc_i        ),
    .debug_req_i  ( debug_req_i  ),
    .rdata_o      ( rdata_o      ),
    .rvalid_o     ( rvalid_o     ),
    .decode_err_o ( decode_err_o ),
    .timer_irq_o  ( timer_irq_o  ),
    .ipi_o        ( ipi_o        ),
    .debug_req_o  ( debug_req_o  )
  );

  always #5 clk_i = ~clk_i;

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  function automatic logic [AddrWidth-1:0] hart_addr(region_e r, int unsigned h);
    int unsigned stride;
    stride = (r == MSIP) ? MsipStride : MtimecmpStride;
    return AddrMap[r].start_addr + AddrWidth'(h * stride);
  endfunction

  function automatic logic [NumHarts-1:0] hart_vec(int kind);
    case (kind)
      0:       return debug_req_o;
      1:       return timer_irq_o;
      default: return ipi_o;
    endcase
  endfunction

  task automatic add_step(input logic we, input logic [AddrWidth-1:0] addr,
                          input logic [DataWidth-1:0] wdata,
                          input logic [DataWidth-1:0] exp_rdata, input logic exp_err);
    step_t s;
    s.we        = we;
    s.addr      = addr;
    s.wdata     = wdata;
    s.exp_rdata = exp_rdata;
    s.exp_err   = exp_err;
    table_q.push_back(s);
  endtask

  // Called on a falling edge, returns on a falling edge
  task automatic run_table();
    step_t s;
    int    cnt;
    for (int i = 0; i < table_q.size(); i++) begin
      s       = table_q[i];
      req_i   = 1'b1;
      we_i    = s.we;
      addr_i  = s.addr;
      wdata_i = s.wdata;
      @(negedge clk_i);
      req_i = 1'b0;
      we_i  = 1'b0;
      if (s.we && !s.exp_err) begin
        assert (!rvalid_o && !decode_err_o) else begin
          $display("FAIL %0t: unexpected response to mapped write at %h", $time, s.addr);
          value_errs++;
        end
      end else begin
        cnt = 0;
        while (!rvalid_o && cnt < Timeout) begin
          @(negedge clk_i);
          cnt++;
        end
        assert (rvalid_o) else begin
          $display("No response within %0d cycles to the access at %h", Timeout, s.addr);
          timeout_errs++;
        end
        if (rvalid_o) begin
          assert (rdata_o == s.exp_rdata && decode_err_o == s.exp_err) else begin
            $display("FAIL %0t: %s %h gave data %h err %b, expected %h err %b", $time,
                     s.we ? "write" : "read", s.addr, rdata_o, decode_err_o,
                     s.exp_rdata, s.exp_err);
            value_errs++;
          end
        end
      end
    end
    table_q.delete();
  endtask

  task automatic wait_hart_vec(input int kind, input logic [NumHarts-1:0] exp,
                               input string name);
    int cnt;
    cnt = 0;
    while (hart_vec(kind) !== exp && cnt < Timeout) begin
      @(negedge clk_i);
      cnt++;
    end
    assert (hart_vec(kind) === exp) else begin
      $display("Gave up waiting for %s to become %b, it is still %b", name, exp, hart_vec(kind));
      timeout_errs++;
    end
  endtask

  // ------------------------------------------------------------
  // Test sequence
  // ------------------------------------------------------------
  initial begin : p_main
    logic [NumHarts-1:0]  pattern;
    logic [DataWidth-1:0] wd;
    void'($urandom(38702));
    clk_i        = 1'b0;
    ndmreset_n   = 1'b0;
    req_i        = 1'b0;
    we_i         = 1'b0;
    addr_i       = '0;
    wdata_i      = '0;
    rtc_i        = 1'b0;
    debug_req_i  = '1;
    value_errs   = 0;
    timeout_errs = 0;
    mtime_model  = '0;
    for (int h = 0; h < NumHarts; h++) begin
      cmp_model[h]  = MtimecmpReset;
      msip_model[h] = 1'b0;
      rand_word[h]  = {$urandom, $urandom};
    end
    repeat (8) @(negedge clk_i);
    ndmreset_n = 1'b1;

    // Debug hold-off, then pass-through
    for (int i = 0; i < DebugDelayCycles - 2; i++) begin
      @(negedge clk_i);
      assert (debug_req_o == '0) else begin
        $display("FAIL %0t: debug_req_o %b in hold-off cycle %0d", $time, debug_req_o, i);
        value_errs++;
      end
    end
    wait_hart_vec(0, '1, "debug_req_o");
    debug_req_i = NumHarts'(4'b0110);
    wait_hart_vec(0, NumHarts'(4'b0110), "debug_req_o");
    debug_req_i = '0;
    wait_hart_vec(0, '0, "debug_req_o");

    // mtime write, then four rtc edges give two ticks
    mtime_model = {1'b0, rand_word[0][TimeWidth-2:0]};
    add_step(1'b1, MtimeBase, mtime_model, '0, 1'b0);
    add_step(1'b0, MtimeBase, '0, mtime_model, 1'b0);
    run_table();
    repeat (4) begin
      rtc_i = 1'b1;
      repeat (4) @(negedge clk_i);
      rtc_i = 1'b0;
      repeat (4) @(negedge clk_i);
    end
    mtime_model = mtime_model + 2;
    add_step(1'b0, MtimeBase, '0, mtime_model, 1'b0);
    run_table();

    // mtimecmp read-back, then only hart 0 below mtime
    for (int h = 0; h < NumHarts; h++) begin
      cmp_model[h] = rand_word[h];
      add_step(1'b1, hart_addr(MTIMECMP, h), rand_word[h], '0, 1'b0);
      add_step(1'b0, hart_addr(MTIMECMP, h), '0, cmp_model[h], 1'b0);
    end
    run_table();
    for (int h = 0; h < NumHarts; h++) begin
      cmp_model[h] = (h == 0) ? mtime_model - 1 : '1;
      add_step(1'b1, hart_addr(MTIMECMP, h), cmp_model[h], '0, 1'b0);
    end
    run_table();
    wait_hart_vec(1, NumHarts'(1), "timer_irq_o");

    // msip keeps only bit 0 of the word
    pattern = NumHarts'(4'b1010);
    for (int h = 0; h < NumHarts; h++) begin
      wd            = {rand_word[h][DataWidth-1:1], pattern[h]};
      msip_model[h] = pattern[h];
      add_step(1'b1, hart_addr(MSIP, h), wd, '0, 1'b0);
    end
    for (int h = 0; h < NumHarts; h++) begin
      add_step(1'b0, hart_addr(MSIP, h), '0, DataWidth'(msip_model[h]), 1'b0);
    end
    run_table();
    wait_hart_vec(2, pattern, "ipi_o");

    // Unmapped accesses, then everything must read back unchanged
    add_step(1'b0, hart_addr(MSIP, NumHarts), '0, '0, 1'b1);
    add_step(1'b0, MtimeBase + 32'd8, '0, '0, 1'b1);
    add_step(1'b1, hart_addr(MTIMECMP, NumHarts), rand_word[1], '0, 1'b1);
    add_step(1'b1, MtimeBase + 32'd8, rand_word[2], '0, 1'b1);
    add_step(1'b0, MtimeBase, '0, mtime_model, 1'b0);
    for (int h = 0; h < NumHarts; h++) begin
      add_step(1'b0, hart_addr(MTIMECMP, h), '0, cmp_model[h], 1'b0);
      add_step(1'b0, hart_addr(MSIP, h), '0, DataWidth'(msip_model[h]), 1'b0);
    end
    run_table();

    $display("Errors: %0d value mismatches, %0d timeouts", value_errs, timeout_errs);
    if (value_errs == 0 && timeout_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
rtl/soc_map_pkg.sv
rtl/hart_ctrl_pkg.sv
rtl/mtime_counter.sv
rtl/clint_addr_decoder.sv
rtl/hart_timer_slice.sv
rtl/hart_irq_collector.sv
rtl/clint_subsystem.sv
testbench/tb_clint_subsystem.sv
